/* logic/apb_regs.sv */
`timescale 1ns/1ps
module apb_regs (
    input  logic                               clk,
    input  logic                               rst_n,
    input  kp_pkg::apb_req_t                   req,
    output kp_pkg::apb_rsp_t                   rsp,
    output kp_pkg::img_wr_t                    img_wr,
    output logic                               start,
    output kp_pkg::pixel_t                     threshold,
    input  logic                               busy,
    input  logic                               done_pulse,
    input  logic [$clog2(kp_pkg::KP_DEPTH):0]  kp_count,
    output kp_pkg::kp_addr_t                   kp_rd_addr,
    input  kp_pkg::kp_entry_t                  kp_rd_data
);
    import kp_pkg::*;

    localparam int IMG_BYTES = IMG_H * WORDS_PER_ROW * 4;
    localparam int KP_BYTES  = KP_DEPTH * 4;

    logic setup, access, wr_acc;
    logic is_ctrl, is_status, is_thresh, is_kpcnt;
    logic in_img, in_kp, mapped, err;
    logic [APB_AW-1:0] img_off, kp_off;
    logic [APB_AW-3:0] img_idx;
    logic done;
    logic [APB_DW-1:0] rd_mux, prdata_q;

    assign setup  = req.psel && !req.penable;
    assign access = req.psel && req.penable;
    assign wr_acc = access && req.pwrite;

    assign is_ctrl   = req.paddr == CTRL_OFS;
    assign is_status = req.paddr == STATUS_OFS;
    assign is_thresh = req.paddr == THRESH_OFS;
    assign is_kpcnt  = req.paddr == KPCNT_OFS;
    assign in_img    = req.paddr >= IMG_BASE && req.paddr < IMG_BASE + IMG_BYTES;
    assign in_kp     = req.paddr >= KP_BASE && req.paddr < KP_BASE + KP_BYTES;
    assign mapped    = is_ctrl || is_status || is_thresh || is_kpcnt || in_img || in_kp;

    assign err = !mapped || (in_kp && req.pwrite) || (in_img && !req.pwrite)
               || (in_img && req.pwrite && busy);

    assign img_off = req.paddr - IMG_BASE;
    assign kp_off  = req.paddr - KP_BASE;
    assign img_idx = img_off[APB_AW-1:2];  // row * WORDS_PER_ROW + word

    assign img_wr.en   = wr_acc && in_img && !busy;
    assign img_wr.row  = row_addr_t'(img_idx / WORDS_PER_ROW);
    assign img_wr.word = $bits(img_wr.word)'(img_idx % WORDS_PER_ROW);
    assign img_wr.data = req.pwdata;

    assign kp_rd_addr = kp_addr_t'(kp_off[APB_AW-1:2]);

    assign start = wr_acc && is_ctrl && req.pwdata[0] && !busy;  // ignored while busy

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            threshold <= '0;
            done <= 1'b0;
        end else begin
            if (wr_acc && is_thresh) begin
                threshold <= req.pwdata[PIX_W-1:0];
            end
            if (start) begin
                done <= 1'b0;
            end else if (done_pulse) begin
                done <= 1'b1;
            end
        end
    end

    always_comb begin
        rd_mux = '0;
        if (!err) begin
            if (is_status) begin
                rd_mux[1:0] = {done, busy};
            end else if (is_thresh) begin
                rd_mux[PIX_W-1:0] = threshold;
            end else if (is_kpcnt) begin
                rd_mux[$bits(kp_count)-1:0] = kp_count;
            end else if (in_kp) begin
                rd_mux[8 +: $bits(row_addr_t)] = kp_rd_data.row;
                rd_mux[0 +: $bits(kp_rd_data.col)] = kp_rd_data.col;
            end
        end
    end

    // sampled in setup, presented in access
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            prdata_q <= '0;
        end else if (setup && !req.pwrite) begin
            prdata_q <= rd_mux;
        end
    end

    assign rsp.prdata  = prdata_q;
    assign rsp.pready  = 1'b1;
    assign rsp.pslverr = access && err;

    a_penable_psel: assert property (@(posedge clk) disable iff (!rst_n)
        req.penable |-> req.psel)
        else $error("apb penable without psel");

endmodule

/* logic/core_ctrl.sv */
`timescale 1ns/1ps
module core_ctrl #(
    parameter int IMG_H = kp_pkg::IMG_H,
    parameter int IMG_W = kp_pkg::IMG_W
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              start,
    output logic              busy,
    output logic              done_pulse,
    output kp_pkg::row_addr_t mem_addr,
    output logic              blur_we,
    output logic              buf_shift,
    output logic              buf_fill_zero,
    output logic              scan_start,
    output kp_pkg::row_addr_t scan_row,
    output logic              kp_clear,
    input  logic              row_done
);
    import kp_pkg::*;

    localparam int STEP_W = $clog2(IMG_H + 3);

    typedef enum logic [1:0] {S_IDLE, S_BLUR, S_DET_RD, S_DET_SCAN} state_t;

    state_t state;
    logic [STEP_W-1:0] step, p1_step;
    logic p1_vld, p1_zero, p2_vld;
    row_addr_t p2_row, det_row;
    logic issue, last_row, go;

    assign go       = state == S_IDLE && start;
    assign issue    = state == S_BLUR && step < IMG_H + 2;  // rows, then two zero steps
    assign last_row = det_row == row_addr_t'(IMG_H - 1);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= S_IDLE;
            step <= '0;
            det_row <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (start) begin
                        state <= S_BLUR;
                        step <= '0;
                    end
                end
                S_BLUR: begin
                    step <= step + 1'b1;
                    if (step == STEP_W'(IMG_H + 2)) begin  // last write drained
                        state <= S_DET_RD;
                        det_row <= '0;
                    end
                end
                S_DET_RD: state <= S_DET_SCAN;
                S_DET_SCAN: begin
                    if (row_done) begin
                        det_row <= det_row + 1'b1;
                        state <= last_row ? S_IDLE : S_DET_RD;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // stage 1 is the line buffer shift, stage 2 the blur write
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            p1_vld <= 1'b0;
            p1_zero <= 1'b0;
            p2_vld <= 1'b0;
        end else begin
            p1_vld <= issue;
            p1_zero <= issue && step >= IMG_H;
            p2_vld <= p1_vld && p1_step != '0 && p1_step <= IMG_H;
        end
    end

    always_ff @(posedge clk) begin
        p1_step <= step;
        p2_row <= row_addr_t'(p1_step - 1'b1);  // row centred in the buffer
    end

    assign busy          = state != S_IDLE;
    assign done_pulse    = state == S_DET_SCAN && row_done && last_row;
    assign mem_addr      = (state == S_BLUR) ? row_addr_t'(step) : det_row;
    assign scan_row      = (state == S_BLUR) ? p2_row : det_row;
    assign blur_we       = p2_vld;
    assign buf_shift     = p1_vld;
    assign buf_fill_zero = p1_zero || go;
    assign scan_start    = state == S_DET_RD;
    assign kp_clear      = go;

    a_we_scan_excl: assert property (@(posedge clk) disable iff (!rst_n)
        !(blur_we && scan_start))
        else $error("blur write overlaps detect start");

    a_row_done_time: assert property (@(posedge clk) disable iff (!rst_n)
        scan_start |-> ##(IMG_W + 1) row_done)
        else $error("row_done not at end of column scan");

endmodule

/* logic/gaussian_row.sv */
`timescale 1ns/1ps
module gaussian_row (
    input  kp_pkg::row_t top,
    input  kp_pkg::row_t mid,
    input  kp_pkg::row_t bot,
    output kp_pkg::row_t blur
);
    import kp_pkg::*;

    // vertical 1-2-1 per column, padded by one zero column on each side
    logic [PIX_W+1:0] vsum [IMG_W+2];
    logic [PIX_W+3:0] hsum [IMG_W];

    always_comb begin
        vsum[0] = '0;
        vsum[IMG_W+1] = '0;
        for (int c = 0; c < IMG_W; c++) begin
            vsum[c+1] = top[c] + (mid[c] << 1) + bot[c];
        end
    end

    always_comb begin
        for (int c = 0; c < IMG_W; c++) begin
            hsum[c] = vsum[c] + (vsum[c+1] << 1) + vsum[c+2] + 4'd8;  // round
            blur[c] = hsum[c][PIX_W+3:4];  // divide by 16
        end
    end

endmodule

/* logic/keypoint_detect.sv */
`timescale 1ns/1ps
module keypoint_detect #(
    parameter int IMG_H = kp_pkg::IMG_H,
    parameter int IMG_W = kp_pkg::IMG_W
) (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              scan_start,
    input  kp_pkg::row_addr_t                 row,
    input  kp_pkg::row_t                      orig,
    input  kp_pkg::row_t                      blur,
    input  kp_pkg::pixel_t                    threshold,
    input  logic                              clear,
    output logic                              row_done,
    output logic [$clog2(kp_pkg::KP_DEPTH):0] count,
    input  kp_pkg::kp_addr_t                  rd_addr,
    output kp_pkg::kp_entry_t                 rd_data
);
    import kp_pkg::*;

    localparam int COL_W = $clog2(IMG_W);

    kp_entry_t kp_mem [KP_DEPTH];

    logic active;
    logic [COL_W-1:0] col;
    pixel_t o_pix, b_pix, diff;
    logic interior, hit;

    assign o_pix = orig[col];
    assign b_pix = blur[col];
    assign diff  = (o_pix > b_pix) ? o_pix - b_pix : b_pix - o_pix;

    assign interior = row != '0 && row < IMG_H - 1 && col != '0 && col < IMG_W - 1;
    assign hit = active && interior && diff > threshold;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            active <= 1'b0;
            col <= '0;
            row_done <= 1'b0;
            count <= '0;
        end else begin
            row_done <= active && col == COL_W'(IMG_W - 1);
            if (scan_start) begin
                active <= 1'b1;
                col <= '0;
            end else if (active) begin
                col <= col + 1'b1;
                if (col == COL_W'(IMG_W - 1)) begin
                    active <= 1'b0;
                end
            end
            if (clear) begin
                count <= '0;
            end else if (hit) begin
                count <= count + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (hit) begin
            kp_mem[kp_addr_t'(count)] <= '{row: row, col: col};  // raster order
        end
    end

    assign rd_data = kp_mem[rd_addr];

    a_count_bound: assert property (@(posedge clk) disable iff (!rst_n)
        count <= KP_DEPTH)
        else $error("keypoint count past memory depth");

endmodule

/* logic/kp_core.sv */
`timescale 1ns/1ps
module kp_core #(
    parameter int IMG_H = kp_pkg::IMG_H,
    parameter int IMG_W = kp_pkg::IMG_W
) (
    input  logic             clk,
    input  logic             rst_n,
    input  kp_pkg::apb_req_t req,
    output kp_pkg::apb_rsp_t rsp
);
    import kp_pkg::*;

    img_wr_t img_wr;
    logic start, busy, done_pulse;
    pixel_t threshold;
    logic [$clog2(KP_DEPTH):0] kp_count;
    kp_addr_t kp_rd_addr;
    kp_entry_t kp_rd_data;

    row_addr_t mem_addr, scan_row, img_addr;
    logic blur_we, buf_shift, buf_fill_zero, scan_start, kp_clear, row_done;
    logic [WORDS_PER_ROW-1:0] host_mask, img_we;
    row_t img_din, img_dout, blur_din, blur_dout;
    row_t buf_top, buf_mid, buf_bot;

    // host owns the image memory only while idle
    assign host_mask = {WORDS_PER_ROW{img_wr.en}} & (WORDS_PER_ROW'(1) << img_wr.word);
    assign img_we    = busy ? '0 : host_mask;
    assign img_addr  = busy ? mem_addr : img_wr.row;
    assign img_din   = {WORDS_PER_ROW{img_wr.data}};

    apb_regs u_regs (
        .clk(clk), .rst_n(rst_n), .req(req), .rsp(rsp),
        .img_wr(img_wr), .start(start), .threshold(threshold),
        .busy(busy), .done_pulse(done_pulse), .kp_count(kp_count),
        .kp_rd_addr(kp_rd_addr), .kp_rd_data(kp_rd_data)
    );

    core_ctrl #(.IMG_H(IMG_H), .IMG_W(IMG_W)) u_ctrl (
        .clk(clk), .rst_n(rst_n), .start(start), .busy(busy),
        .done_pulse(done_pulse), .mem_addr(mem_addr), .blur_we(blur_we),
        .buf_shift(buf_shift), .buf_fill_zero(buf_fill_zero),
        .scan_start(scan_start), .scan_row(scan_row), .kp_clear(kp_clear),
        .row_done(row_done)
    );

    row_mem img_mem (
        .clk(clk), .we(img_we), .addr(img_addr), .din(img_din), .dout(img_dout)
    );

    row_mem blur_mem (
        .clk(clk), .we({WORDS_PER_ROW{blur_we}}), .addr(scan_row),
        .din(blur_din), .dout(blur_dout)
    );

    line_buffer u_lbuf (
        .clk(clk), .rst_n(rst_n), .shift(buf_shift), .fill_zero(buf_fill_zero),
        .din(img_dout), .top(buf_top), .mid(buf_mid), .bot(buf_bot)
    );

    gaussian_row u_gauss (
        .top(buf_top), .mid(buf_mid), .bot(buf_bot), .blur(blur_din)
    );

    keypoint_detect #(.IMG_H(IMG_H), .IMG_W(IMG_W)) u_detect (
        .clk(clk), .rst_n(rst_n), .scan_start(scan_start), .row(scan_row),
        .orig(img_dout), .blur(blur_dout), .threshold(threshold),
        .clear(kp_clear), .row_done(row_done), .count(kp_count),
        .rd_addr(kp_rd_addr), .rd_data(kp_rd_data)
    );

endmodule

/* logic/kp_pkg.sv */
package kp_pkg;

    localparam int IMG_W = 16;
    localparam int IMG_H = 16;
    localparam int PIX_W = 8;

    localparam int APB_AW = 12;
    localparam int APB_DW = 32;

    localparam int WORDS_PER_ROW = IMG_W * PIX_W / APB_DW;  // 4 host words per row
    localparam int KP_DEPTH = 256;

    localparam logic [APB_AW-1:0] CTRL_OFS   = 12'h000;
    localparam logic [APB_AW-1:0] STATUS_OFS = 12'h004;
    localparam logic [APB_AW-1:0] THRESH_OFS = 12'h008;
    localparam logic [APB_AW-1:0] KPCNT_OFS  = 12'h00C;
    localparam logic [APB_AW-1:0] IMG_BASE   = 12'h400;
    localparam logic [APB_AW-1:0] KP_BASE    = 12'h800;

    typedef logic [PIX_W-1:0] pixel_t;
    typedef pixel_t [IMG_W-1:0] row_t;  // column 0 in the low byte
    typedef logic [$clog2(IMG_H)-1:0] row_addr_t;
    typedef logic [$clog2(KP_DEPTH)-1:0] kp_addr_t;

    typedef struct packed {
        row_addr_t row;
        logic [$clog2(IMG_W)-1:0] col;
    } kp_entry_t;

    typedef struct packed {
        logic psel;
        logic penable;
        logic pwrite;
        logic [APB_AW-1:0] paddr;
        logic [APB_DW-1:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [APB_DW-1:0] prdata;
        logic pready;
        logic pslverr;
    } apb_rsp_t;

    typedef struct packed {
        logic en;
        row_addr_t row;
        logic [$clog2(WORDS_PER_ROW)-1:0] word;
        logic [APB_DW-1:0] data;
    } img_wr_t;

endpackage

/* logic/line_buffer.sv */
`timescale 1ns/1ps
module line_buffer (
    input  logic         clk,
    input  logic         rst_n,
    input  logic         shift,
    input  logic         fill_zero,
    input  kp_pkg::row_t din,
    output kp_pkg::row_t top,
    output kp_pkg::row_t mid,
    output kp_pkg::row_t bot
);
    import kp_pkg::*;

    row_t in_row;

    assign in_row = fill_zero ? row_t'('0) : din;  // zero row past the image edge

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            top <= '0;
            mid <= '0;
            bot <= '0;
        end else if (fill_zero && !shift) begin
            // flush all rows at run start
            top <= '0;
            mid <= '0;
            bot <= '0;
        end else if (shift) begin
            top <= mid;
            mid <= bot;
            bot <= in_row;
        end
    end

endmodule

/* logic/row_mem.sv */
`timescale 1ns/1ps
module row_mem (
    input  logic                             clk,
    input  logic [kp_pkg::WORDS_PER_ROW-1:0] we,
    input  kp_pkg::row_addr_t                addr,
    input  kp_pkg::row_t                     din,
    output kp_pkg::row_t                     dout
);
    import kp_pkg::*;

    localparam int PIX_PER_WORD = APB_DW / PIX_W;

    row_t mem [IMG_H];

    always_ff @(posedge clk) begin
        for (int w = 0; w < WORDS_PER_ROW; w++) begin
            if (we[w]) begin
                mem[addr][w*PIX_PER_WORD +: PIX_PER_WORD] <= din[w*PIX_PER_WORD +: PIX_PER_WORD];
            end
        end
        dout <= mem[addr];  // old data on same-address write
    end

endmodule

/* run.sh */
#!/bin/sh
# build and run the kp_core testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module kp_core_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vkp_core_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q '\*\*\* FAILED \*\*\*' sim.log; then
    exit 1
fi
exit 0

/* tb.f */
+incdir+tests
logic/kp_pkg.sv
logic/row_mem.sv
logic/apb_regs.sv
logic/line_buffer.sv
logic/gaussian_row.sv
logic/keypoint_detect.sv
logic/core_ctrl.sv
logic/kp_core.sv
tests/kp_core_tb.sv

/* tests/kp_ref.svh */
`ifndef KP_REF_SVH
`define KP_REF_SVH

typedef row_t image_t [IMG_H];

function automatic int pix_at(input image_t img, input int r, input int c);
    if (r < 0 || r >= IMG_H || c < 0 || c >= IMG_W) begin
        return 0;  // zero fill outside the image
    end
    return int'(img[r][c]);
endfunction

function automatic void ref_blur(input image_t img, output image_t blr);
    int acc;
    for (int r = 0; r < IMG_H; r++) begin
        for (int c = 0; c < IMG_W; c++) begin
            acc = 8;  // rounding
            for (int dr = -1; dr <= 1; dr++) begin
                for (int dc = -1; dc <= 1; dc++) begin
                    acc += (dr == 0 ? 2 : 1) * (dc == 0 ? 2 : 1) * pix_at(img, r + dr, c + dc);
                end
            end
            blr[r][c] = pixel_t'(acc / 16);
        end
    end
endfunction

// returns the keypoint count, entries in raster order
function automatic int ref_keypoints(input image_t img, input image_t blr, input pixel_t thr,
                                     output logic [31:0] kps [KP_DEPTH]);
    int n;
    int d;
    n = 0;
    for (int r = 1; r < IMG_H - 1; r++) begin
        for (int c = 1; c < IMG_W - 1; c++) begin
            d = int'(img[r][c]) - int'(blr[r][c]);
            if (d < 0) begin
                d = -d;
            end
            if (d > int'(thr)) begin
                kps[n] = 32'((r << 8) | c);
                n++;
            end
        end
    end
    return n;
endfunction

`endif

/* tests/kp_core_tb.sv */
`timescale 1ns/1ps
module kp_core_tb;
    import kp_pkg::*;

    `include "kp_ref.svh"

    localparam int RUN_CYCLES = IMG_H * (IMG_W + 2) + IMG_H + 4;
    localparam int NUM_RUNS = 4;
    localparam int APB_XFERS = IMG_H * WORDS_PER_ROW + NUM_RUNS * (KP_DEPTH + 8) + 20;
    localparam longint WATCHDOG_NS = 10 * (NUM_RUNS * RUN_CYCLES + APB_XFERS * 3) * 10;

    logic clk;
    logic rst_n;
    apb_req_t req;
    apb_rsp_t rsp;
    int seed;
    image_t img, blr;
    logic [31:0] exp_kp [KP_DEPTH];
    int exp_cnt;
    logic [31:0] rdata;
    logic slverr;
    logic ready;
    string chk_name [$];
    logic [31:0] chk_exp [$];
    logic [31:0] chk_act [$];

    kp_core dut0 (.clk(clk), .rst_n(rst_n), .req(req), .rsp(rsp));

    initial clk = 1'b0;
    always #5 clk = ~clk;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("*** FAILED ***");
        $fatal(1, "simulation stopped");
    endtask

    task automatic queue_check(input string name, input logic [31:0] exp, input logic [31:0] act);
        chk_name.push_back(name);
        chk_exp.push_back(exp);
        chk_act.push_back(act);
    endtask

    // one zero-wait transfer with results sampled mid access phase
    task automatic apb_xfer(input logic write, input logic [APB_AW-1:0] addr,
                            input logic [APB_DW-1:0] wdata);
        @(posedge clk);
        #1;
        req.psel = 1'b1;
        req.penable = 1'b0;
        req.pwrite = write;
        req.paddr = addr;
        req.pwdata = wdata;
        @(posedge clk);
        #1;
        req.penable = 1'b1;
        #4;
        rdata = rsp.prdata;
        slverr = rsp.pslverr;
        ready = rsp.pready;
        @(posedge clk);
        #1;
        req.psel = 1'b0;
        req.penable = 1'b0;
        queue_check($sformatf("pready @%h", addr), 32'h1, 32'(ready));
    endtask

    task automatic read_check(input logic [APB_AW-1:0] addr, input logic [31:0] exp,
                              input logic exp_err, input string name);
        apb_xfer(1'b0, addr, '0);
        queue_check(name, exp, rdata);
        queue_check($sformatf("pslverr @%h", addr), 32'(exp_err), 32'(slverr));
    endtask

    task automatic write_check(input logic [APB_AW-1:0] addr, input logic [31:0] data,
                               input logic exp_err);
        apb_xfer(1'b1, addr, data);
        queue_check($sformatf("pslverr @%h", addr), 32'(exp_err), 32'(slverr));
    endtask

    task automatic wait_done();
        int polls;
        polls = 0;
        do begin
            apb_xfer(1'b0, STATUS_OFS, '0);
            polls++;
        end while (rdata[1] !== 1'b1 && polls < RUN_CYCLES);
        assert (rdata[1] === 1'b1) else abort_run("run did not finish, done never set");
        queue_check("prdata (STATUS)", 32'h2, rdata);  // done, not busy
    endtask

    task automatic check_results(input pixel_t thr);
        ref_blur(img, blr);
        exp_cnt = ref_keypoints(img, blr, thr, exp_kp);
        read_check(KPCNT_OFS, 32'(exp_cnt), 1'b0, "prdata (KPCNT)");
        for (int i = 0; i < exp_cnt; i++) begin
            read_check(KP_BASE + APB_AW'(i * 4), exp_kp[i], 1'b0,
                       $sformatf("prdata (KP[%0d])", i));
        end
    endtask

    task automatic run_and_check(input pixel_t thr);
        write_check(THRESH_OFS, 32'(thr), 1'b0);
        write_check(CTRL_OFS, 32'h1, 1'b0);
        wait_done();
        check_results(thr);
    endtask

    always @(posedge clk) begin
        string name;
        logic [31:0] exp_v, act_v;
        while (chk_act.size() > 0) begin
            name = chk_name.pop_front();
            exp_v = chk_exp.pop_front();
            act_v = chk_act.pop_front();
            assert (act_v === exp_v) else abort_run($sformatf(
                "mismatch at %0t: %s expected 0x%08h got 0x%08h", $time, name, exp_v, act_v));
        end
    end

    initial begin
        #(WATCHDOG_NS);
        abort_run("watchdog expired before the test finished");
    end

    initial begin
        seed = 13;
        rst_n = 1'b0;
        req = '0;
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;

        read_check(STATUS_OFS, 32'h0, 1'b0, "prdata (STATUS)");
        write_check(THRESH_OFS, 32'h5A, 1'b0);
        read_check(THRESH_OFS, 32'h5A, 1'b0, "prdata (THRESH)");
        write_check(THRESH_OFS, 32'h1A5, 1'b0);
        read_check(THRESH_OFS, 32'hA5, 1'b0, "prdata (THRESH)");  // only 8 bits kept

        for (int r = 0; r < IMG_H; r++) begin
            for (int c = 0; c < IMG_W; c++) begin
                img[r][c] = pixel_t'($random(seed));
            end
        end
        for (int r = 0; r < IMG_H; r++) begin
            for (int w = 0; w < WORDS_PER_ROW; w++) begin
                write_check(IMG_BASE + APB_AW'((r * WORDS_PER_ROW + w) * 4),
                            img[r][w*4 +: 4], 1'b0);
            end
        end

        run_and_check(8'd10);
        run_and_check(8'd255);

        // traffic while busy
        write_check(THRESH_OFS, 32'd10, 1'b0);
        write_check(CTRL_OFS, 32'h1, 1'b0);
        read_check(STATUS_OFS, 32'h1, 1'b0, "prdata (STATUS)");
        write_check(CTRL_OFS, 32'h1, 1'b0);  // ignored start
        write_check(IMG_BASE + 12'h014, 32'hFFFF_FFFF, 1'b1);
        wait_done();
        check_results(8'd10);
        run_and_check(8'd10);  // image must be unchanged

        read_check(12'h010, 32'h0, 1'b1, "prdata (unmapped)");
        write_check(KP_BASE, 32'h0, 1'b1);

        repeat (2) @(posedge clk);
        if (chk_act.size() != 0) begin
            abort_run("compare queue still holds checks at end of test");
        end else begin
            $display("*** PASSED ***");
            $finish;
        end
    end

endmodule
